// ==== rtl/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_RESET_ADDR   32'h0000_0000
`define RV_NUM_REGS     32

// Major opcodes of the supported subset
`define RV_OP_REG       7'b0110011
`define RV_OP_IMM       7'b0010011
`define RV_OP_LUI       7'b0110111
`define RV_OP_JAL       7'b1101111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011

`define RV_F3_ADD       3'b000
`define RV_F3_SLT       3'b010
`define RV_F3_XOR       3'b100
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_LW        3'b010
`define RV_F3_LBU       3'b100
`define RV_F3_SW        3'b010
`define RV_F3_SB        3'b000

`endif

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] rv_word_t;
    typedef logic [4:0]  rv_reg_idx_t;
    typedef logic [3:0]  rv_sel_t;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B                              // Used by LUI
    } rv_alu_op_t;

    typedef enum logic [2:0]
    {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_WB,
        ST_HALT
    } rv_state_t;

endpackage

// ==== rtl/rv_fetch.sv ====
`include "rv_consts.svh"

module rv_fetch
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_fetch_ack,
    input  rv_pkg::rv_word_t    i_instr,
    input  logic                i_pc_load,
    input  rv_pkg::rv_word_t    i_pc_target,
    input  logic                i_pc_step,
    output rv_pkg::rv_word_t    o_pc,
    output rv_pkg::rv_word_t    o_pc_plus4,
    output rv_pkg::rv_word_t    o_instr
);

    import rv_pkg::*;

    rv_word_t   pc_q;
    rv_word_t   pc_plus4;
    rv_word_t   instr_q;

    assign pc_plus4 = pc_q + 32'd4;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc_q <= `RV_RESET_ADDR;
        else if (i_pc_load)
            pc_q <= i_pc_target;                // Taken branch or jump
        else if (i_pc_step)
            pc_q <= pc_plus4;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_fetch_ack)
            instr_q <= i_instr;                 // Held until the next fetch completes
    end

    assign o_pc       = pc_q;
    assign o_pc_plus4 = pc_plus4;
    assign o_instr    = instr_q;

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        pc_q[1:0] == 2'b00);

endmodule

// ==== rtl/rv_decode.sv ====
`include "rv_consts.svh"

module rv_decode
(
    input  rv_pkg::rv_word_t    i_instr,
    output rv_pkg::rv_reg_idx_t o_rs1,
    output rv_pkg::rv_reg_idx_t o_rs2,
    output rv_pkg::rv_reg_idx_t o_rd,
    output rv_pkg::rv_word_t    o_imm,
    output rv_pkg::rv_alu_op_t  o_alu_op,
    output logic [2:0]          o_funct3,
    output logic                o_use_imm,
    output logic                o_reg_write,
    output logic                o_load,
    output logic                o_store,
    output logic                o_branch,
    output logic                o_jump,
    output logic                o_illegal
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    rv_word_t   imm_i;
    rv_word_t   imm_s;
    rv_word_t   imm_b;
    rv_word_t   imm_u;
    rv_word_t   imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign alt    = (funct7 == 7'b0100000);

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];
    assign o_funct3 = funct3;

    always_comb
    begin
        o_imm       = imm_i;
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b0;
        o_reg_write = 1'b0;
        o_load      = 1'b0;
        o_store     = 1'b0;
        o_branch    = 1'b0;
        o_jump      = 1'b0;
        o_illegal   = 1'b0;
        case (opcode)
            `RV_OP_REG:
            begin
                o_reg_write = 1'b1;
                o_illegal   = (funct7 != 7'b0) && !(alt && (funct3 == `RV_F3_ADD));
                case (funct3)
                    `RV_F3_ADD: o_alu_op = alt ? ALU_SUB : ALU_ADD;
                    `RV_F3_SLT: o_alu_op = ALU_SLT;
                    `RV_F3_XOR: o_alu_op = ALU_XOR;
                    `RV_F3_OR:  o_alu_op = ALU_OR;
                    `RV_F3_AND: o_alu_op = ALU_AND;
                    default:    o_illegal = 1'b1;   // Shifts and SLTU
                endcase
            end
            `RV_OP_IMM:
            begin
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
                case (funct3)
                    `RV_F3_ADD: o_alu_op = ALU_ADD;
                    `RV_F3_XOR: o_alu_op = ALU_XOR;
                    `RV_F3_OR:  o_alu_op = ALU_OR;
                    `RV_F3_AND: o_alu_op = ALU_AND;
                    default:    o_illegal = 1'b1;
                endcase
            end
            `RV_OP_LUI:
            begin
                o_imm       = imm_u;
                o_alu_op    = ALU_PASS_B;
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            `RV_OP_JAL:
            begin
                o_imm       = imm_j;
                o_jump      = 1'b1;
                o_reg_write = 1'b1;
            end
            `RV_OP_BRANCH:
            begin
                o_imm     = imm_b;
                o_branch  = 1'b1;
                o_illegal = (funct3 != `RV_F3_BEQ) && (funct3 != `RV_F3_BNE);
            end
            `RV_OP_LOAD:
            begin
                o_load      = 1'b1;
                o_reg_write = 1'b1;
                o_illegal   = (funct3 != `RV_F3_LW) && (funct3 != `RV_F3_LBU);
            end
            `RV_OP_STORE:
            begin
                o_imm     = imm_s;                  // Operand b stays rs2 as the store data
                o_store   = 1'b1;
                o_illegal = (funct3 != `RV_F3_SW) && (funct3 != `RV_F3_SB);
            end
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

// ==== rtl/rv_regs.sv ====
`include "rv_consts.svh"

module rv_regs
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  rv_pkg::rv_reg_idx_t i_rs1,
    input  rv_pkg::rv_reg_idx_t i_rs2,
    input  rv_pkg::rv_reg_idx_t i_rd,
    input  logic                i_write,
    input  rv_pkg::rv_word_t    i_data,
    output rv_pkg::rv_word_t    o_data1,
    output rv_pkg::rv_word_t    o_data2
);

    import rv_pkg::*;

    rv_word_t   regs_q [`RV_NUM_REGS];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (i_write && (i_rd != '0))
            regs_q[i_rd] <= i_data;             // x0 is never written and reads as zero
    end

    assign o_data1 = regs_q[i_rs1];
    assign o_data2 = regs_q[i_rs2];

    a_write_idx_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_write |-> !$isunknown(i_rd));

endmodule

// ==== rtl/rv_alu.sv ====
`include "rv_consts.svh"

module rv_alu
(
    input  rv_pkg::rv_alu_op_t  i_op,
    input  rv_pkg::rv_word_t    i_a,
    input  rv_pkg::rv_word_t    i_b,
    input  rv_pkg::rv_word_t    i_pc,
    input  rv_pkg::rv_word_t    i_imm,
    input  rv_pkg::rv_word_t    i_load_word,
    input  logic [2:0]          i_funct3,
    input  logic                i_branch,
    input  logic                i_jump,
    output rv_pkg::rv_word_t    o_result,
    output rv_pkg::rv_word_t    o_target,
    output rv_pkg::rv_word_t    o_store_data,
    output rv_pkg::rv_word_t    o_load_data,
    output logic                o_take_branch,
    output rv_pkg::rv_sel_t     o_sel
);

    import rv_pkg::*;

    rv_word_t   base;
    logic [1:0] lane;
    logic       equal;
    logic       byte_access;

    always_comb
    begin
        case (i_op)
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = {31'b0, $signed(i_a) < $signed(i_b)};
            ALU_PASS_B: o_result = i_b;
            default:    o_result = i_a + i_b;
        endcase
    end

    // One adder serves both control flow targets and load/store addresses
    assign base     = (i_branch || i_jump) ? i_pc : i_a;
    assign o_target = base + i_imm;
    assign lane     = o_target[1:0];

    assign equal         = (i_a == i_b);
    assign o_take_branch = i_jump ||
                           (i_branch && ((i_funct3 == `RV_F3_BEQ) ? equal : !equal));

    assign byte_access  = (i_funct3[1:0] == 2'b00); // SB and LBU
    assign o_sel        = byte_access ? rv_sel_t'(4'b0001 << lane) : 4'b1111;
    assign o_store_data = (i_funct3 == `RV_F3_SB) ? {4{i_b[7:0]}} : i_b;

    always_comb
    begin
        if (i_funct3 == `RV_F3_LBU)
            o_load_data = {24'b0, i_load_word[lane*8 +: 8]};
        else
            o_load_data = i_load_word;
    end

endmodule

// ==== rtl/rv_core.sv ====
module rv_core
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    output rv_pkg::rv_word_t    o_wb_adr,
    output rv_pkg::rv_word_t    o_wb_dat,
    input  rv_pkg::rv_word_t    i_wb_dat,
    output rv_pkg::rv_sel_t     o_wb_sel,
    output logic                o_wb_we,
    output logic                o_wb_stb,
    output logic                o_wb_cyc,
    input  logic                i_wb_ack,
    output logic                o_trap
);

    import rv_pkg::*;

    rv_state_t      state_q;
    rv_state_t      state_next;
    logic           cyc_q;
    logic           bus_ack;
    logic           data_phase;
    rv_word_t       pc;
    rv_word_t       pc_plus4;
    rv_word_t       instr;
    rv_reg_idx_t    dec_rs1;
    rv_reg_idx_t    dec_rs2;
    rv_reg_idx_t    dec_rd;
    rv_word_t       dec_imm;
    rv_alu_op_t     dec_alu_op;
    logic [2:0]     dec_funct3;
    logic           dec_use_imm;
    logic           dec_reg_write;
    logic           dec_load;
    logic           dec_store;
    logic           dec_branch;
    logic           dec_jump;
    logic           dec_illegal;
    rv_word_t       reg_data1;
    rv_word_t       reg_data2;
    rv_word_t       op_a_q;
    rv_word_t       op_b_q;
    rv_word_t       result_q;
    rv_word_t       alu_result;
    rv_word_t       alu_target;
    rv_word_t       alu_store_data;
    rv_word_t       alu_load_data;
    logic           alu_take;
    rv_sel_t        alu_sel;

    assign bus_ack    = cyc_q && i_wb_ack;
    assign data_phase = (state_q == ST_MEM);

    always_comb
    begin
        state_next = state_q;
        case (state_q)
            ST_FETCH:
                if (bus_ack)
                    state_next = ST_DECODE;
            ST_DECODE: state_next = dec_illegal ? ST_HALT : ST_EXEC;
            ST_EXEC:   state_next = (dec_load || dec_store) ? ST_MEM : ST_WB;
            ST_MEM:
                if (bus_ack)
                    state_next = ST_WB;
            ST_WB:     state_next = ST_FETCH;
            ST_HALT:   state_next = ST_HALT;            // Left only through reset
            default:   state_next = ST_HALT;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state_q <= ST_FETCH;
            cyc_q   <= 1'b0;
        end
        else
        begin
            state_q <= state_next;
            cyc_q   <= (state_next == ST_FETCH) || (state_next == ST_MEM);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state_q == ST_DECODE)
        begin
            op_a_q <= reg_data1;
            op_b_q <= dec_use_imm ? dec_imm : reg_data2;
        end
    end

    // The link value is taken before the PC moves on the same edge
    always_ff @(posedge i_clk)
    begin
        if (state_q == ST_EXEC)
            result_q <= dec_jump ? pc_plus4 : alu_result;
        else if (data_phase && bus_ack && dec_load)
            result_q <= alu_load_data;
    end

    rv_fetch u_fetch
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_fetch_ack    ((state_q == ST_FETCH) && bus_ack),
        .i_instr        (i_wb_dat),
        .i_pc_load      ((state_q == ST_EXEC) && alu_take),
        .i_pc_target    (alu_target),
        .i_pc_step      ((state_q == ST_EXEC) && !alu_take),
        .o_pc           (pc),
        .o_pc_plus4     (pc_plus4),
        .o_instr        (instr)
    );

    rv_decode u_decode
    (
        .i_instr        (instr),
        .o_rs1          (dec_rs1),
        .o_rs2          (dec_rs2),
        .o_rd           (dec_rd),
        .o_imm          (dec_imm),
        .o_alu_op       (dec_alu_op),
        .o_funct3       (dec_funct3),
        .o_use_imm      (dec_use_imm),
        .o_reg_write    (dec_reg_write),
        .o_load         (dec_load),
        .o_store        (dec_store),
        .o_branch       (dec_branch),
        .o_jump         (dec_jump),
        .o_illegal      (dec_illegal)
    );

    rv_regs u_regs
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_rs1          (dec_rs1),
        .i_rs2          (dec_rs2),
        .i_rd           (dec_rd),
        .i_write        ((state_q == ST_WB) && dec_reg_write),
        .i_data         (result_q),
        .o_data1        (reg_data1),
        .o_data2        (reg_data2)
    );

    rv_alu u_alu
    (
        .i_op           (dec_alu_op),
        .i_a            (op_a_q),
        .i_b            (op_b_q),
        .i_pc           (pc),
        .i_imm          (dec_imm),
        .i_load_word    (i_wb_dat),
        .i_funct3       (dec_funct3),
        .i_branch       (dec_branch),
        .i_jump         (dec_jump),
        .o_result       (alu_result),
        .o_target       (alu_target),
        .o_store_data   (alu_store_data),
        .o_load_data    (alu_load_data),
        .o_take_branch  (alu_take),
        .o_sel          (alu_sel)
    );

    assign o_wb_cyc = cyc_q;
    assign o_wb_stb = cyc_q && ((state_q == ST_FETCH) || data_phase);
    assign o_wb_we  = o_wb_stb && data_phase && dec_store;
    assign o_wb_adr = data_phase ? alu_target : pc;         // Operand latches hold it in MEM
    assign o_wb_sel = data_phase ? alu_sel : 4'b1111;
    assign o_wb_dat = alu_store_data;
    assign o_trap   = (state_q == ST_HALT);

    a_cyc_drop_after_ack: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        bus_ack |=> !o_wb_cyc);

    a_adr_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_wb_stb && !i_wb_ack) |=> $stable(o_wb_adr));

endmodule

// ==== sim/rv_clock_gen.sv ====
module rv_clock_gen
(
    output logic    o_clk,
    output logic    o_reset_n
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        o_clk = 1'b0;
        forever
            #(HALF_PERIOD) o_clk = ~o_clk;
    end

    initial
    begin
        o_reset_n <= 1'b0;
        repeat (RESET_CYCLES)
            @(posedge o_clk);
        o_reset_n <= 1'b1;                      // The core sees reset low on four rising edges
    end

endmodule

// ==== sim/rv_tb_mem.sv ====
module rv_tb_mem
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_cyc,
    input  logic                i_stb,
    input  logic                i_we,
    input  rv_pkg::rv_word_t    i_adr,
    input  rv_pkg::rv_word_t    i_dat,
    input  rv_pkg::rv_sel_t     i_sel,
    output logic                o_ack,
    output rv_pkg::rv_word_t    o_dat,
    output logic                o_log_valid,
    output rv_pkg::rv_word_t    o_log_adr,
    output rv_pkg::rv_word_t    o_log_dat,
    output rv_pkg::rv_sel_t     o_log_sel
);

    import rv_pkg::*;

    localparam int MEM_WORDS = 256;

    rv_word_t   mem_q [MEM_WORDS];
    logic       ack_q = 1'b0;
    rv_word_t   dat_q = '0;
    logic [1:0] wait_q;
    logic [1:0] delay_q;
    logic       log_valid_q = 1'b0;
    rv_word_t   log_adr_q;
    rv_word_t   log_dat_q;
    rv_sel_t    log_sel_q;
    integer     seed = 83;
    logic [7:0] word_idx;

    assign word_idx = i_adr[9:2];

    function automatic logic [1:0] draw_ack_delay();
        integer r;
        r = $random(seed);
        return r[1:0];
    endfunction

    task automatic fill_pattern();
        for (int i = 0; i < MEM_WORDS; i++)
            mem_q[i[7:0]] <= ~(i * 4);          // Inverted byte address of the word
    endtask

    task automatic preload_word(input rv_word_t adr, input rv_word_t data);
        mem_q[adr[9:2]] <= data;
    endtask

    always @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ack_q       <= 1'b0;
            wait_q      <= 2'd0;
            delay_q     <= 2'd0;
            log_valid_q <= 1'b0;
        end
        else
        begin
            ack_q       <= 1'b0;
            log_valid_q <= 1'b0;
            if (i_cyc && i_stb && !ack_q)
            begin
                if (wait_q == delay_q)
                begin
                    ack_q   <= 1'b1;
                    dat_q   <= mem_q[word_idx];
                    wait_q  <= 2'd0;
                    delay_q <= draw_ack_delay(); // Latency of the next access
                    if (i_we)
                    begin
                        for (int b = 0; b < 4; b++)
                            if (i_sel[b])
                                mem_q[word_idx][b*8 +: 8] <= i_dat[b*8 +: 8];
                        log_valid_q <= 1'b1;
                        log_adr_q   <= i_adr;
                        log_dat_q   <= i_dat;
                        log_sel_q   <= i_sel;
                    end
                end
                else
                    wait_q <= wait_q + 2'd1;
            end
        end
    end

    assign o_ack       = ack_q;
    assign o_dat       = dat_q;
    assign o_log_valid = log_valid_q;
    assign o_log_adr   = log_adr_q;
    assign o_log_dat   = log_dat_q;
    assign o_log_sel   = log_sel_q;

endmodule

// ==== sim/rv_tb.sv ====
`include "rv_consts.svh"

module rv_tb;

    import rv_pkg::*;

    localparam int       CYCLES_PER_STEP = 40;
    localparam int       RESET_CYCLES    = 4;
    localparam int       IDLE_CYCLES     = 20;  // Bus must stay quiet this long after the trap
    localparam rv_word_t LOAD_ADDR       = 32'h0000_0300;
    localparam rv_word_t LOAD_WORD       = 32'h8123_45C6;

    logic       clk;
    logic       reset_n;
    rv_word_t   wb_adr;
    rv_word_t   wb_dat_w;
    rv_word_t   wb_dat_r;
    rv_sel_t    wb_sel;
    logic       wb_we;
    logic       wb_stb;
    logic       wb_cyc;
    logic       wb_ack;
    logic       trap;
    logic       log_valid;
    rv_word_t   log_adr;
    rv_word_t   log_dat;
    rv_sel_t    log_sel;

    rv_word_t   tbl_instr [$];
    logic       tbl_store [$];
    rv_word_t   tbl_adr [$];
    rv_word_t   tbl_dat [$];
    rv_sel_t    tbl_sel [$];
    int         errors;
    int         checks;
    int         stores_expected;
    int         stores_seen = 0;
    int         bus_after_trap;
    int         watchdog_cycles;

    rv_clock_gen clock0
    (
        .o_clk      (clk),
        .o_reset_n  (reset_n)
    );

    rv_tb_mem mem0
    (
        .i_clk          (clk),
        .i_reset_n      (reset_n),
        .i_cyc          (wb_cyc),
        .i_stb          (wb_stb),
        .i_we           (wb_we),
        .i_adr          (wb_adr),
        .i_dat          (wb_dat_w),
        .i_sel          (wb_sel),
        .o_ack          (wb_ack),
        .o_dat          (wb_dat_r),
        .o_log_valid    (log_valid),
        .o_log_adr      (log_adr),
        .o_log_dat      (log_dat),
        .o_log_sel      (log_sel)
    );

    rv_core dut0
    (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .o_wb_adr   (wb_adr),
        .o_wb_dat   (wb_dat_w),
        .i_wb_dat   (wb_dat_r),
        .o_wb_sel   (wb_sel),
        .o_wb_we    (wb_we),
        .o_wb_stb   (wb_stb),
        .o_wb_cyc   (wb_cyc),
        .i_wb_ack   (wb_ack),
        .o_trap     (trap)
    );

    function automatic rv_word_t encode_reg(input logic [6:0] f7, input logic [2:0] f3,
                                            input rv_reg_idx_t rd, input rv_reg_idx_t rs1,
                                            input rv_reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic rv_word_t encode_imm(input logic [6:0] op, input logic [2:0] f3,
                                            input rv_reg_idx_t rd, input rv_reg_idx_t rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_word_t encode_store(input logic [2:0] f3, input rv_reg_idx_t rs2,
                                              input rv_reg_idx_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic rv_word_t encode_branch(input logic [2:0] f3, input rv_reg_idx_t rs1,
                                               input rv_reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic rv_word_t encode_upper(input logic [6:0] op, input rv_reg_idx_t rd,
                                              input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_word_t encode_jal(input rv_reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic add_step(input rv_word_t instr);
        tbl_instr.push_back(instr);
        tbl_store.push_back(1'b0);
        tbl_adr.push_back('0);
        tbl_dat.push_back('0);
        tbl_sel.push_back('0);
    endtask

    task automatic add_store(input rv_word_t instr, input rv_word_t adr, input rv_word_t dat,
                             input rv_sel_t sel);
        tbl_instr.push_back(instr);
        tbl_store.push_back(1'b1);
        tbl_adr.push_back(adr);
        tbl_dat.push_back(dat);
        tbl_sel.push_back(sel);
        stores_expected++;
    endtask

    // x1 = 100 and x2 = -7 feed the register operations while x10 points at the result area
    task automatic build_program();
        add_step(encode_imm(`RV_OP_IMM, `RV_F3_ADD, 5'd10, 5'd0, 12'h200));
        add_step(encode_imm(`RV_OP_IMM, `RV_F3_ADD, 5'd1, 5'd0, 12'd100));
        add_step(encode_imm(`RV_OP_IMM, `RV_F3_ADD, 5'd2, 5'd0, 12'hFF9));
        add_step(encode_reg(7'b0000000, `RV_F3_ADD, 5'd3, 5'd1, 5'd2));
        add_store(encode_store(`RV_F3_SW, 5'd3, 5'd10, 12'd0), 32'h200, 32'h0000_005D, 4'hF);
        add_step(encode_reg(7'b0100000, `RV_F3_ADD, 5'd4, 5'd1, 5'd2));
        add_store(encode_store(`RV_F3_SW, 5'd4, 5'd10, 12'd4), 32'h204, 32'h0000_006B, 4'hF);
        add_step(encode_reg(7'b0000000, `RV_F3_AND, 5'd5, 5'd1, 5'd2));
        add_store(encode_store(`RV_F3_SW, 5'd5, 5'd10, 12'd8), 32'h208, 32'h0000_0060, 4'hF);
        add_step(encode_reg(7'b0000000, `RV_F3_OR, 5'd6, 5'd1, 5'd2));
        add_store(encode_store(`RV_F3_SW, 5'd6, 5'd10, 12'd12), 32'h20C, 32'hFFFF_FFFD, 4'hF);
        add_step(encode_reg(7'b0000000, `RV_F3_XOR, 5'd7, 5'd1, 5'd2));
        add_store(encode_store(`RV_F3_SW, 5'd7, 5'd10, 12'd16), 32'h210, 32'hFFFF_FF9D, 4'hF);
        add_step(encode_reg(7'b0000000, `RV_F3_SLT, 5'd8, 5'd2, 5'd1));   // -7 < 100
        add_store(encode_store(`RV_F3_SW, 5'd8, 5'd10, 12'd20), 32'h214, 32'h0000_0001, 4'hF);
        add_step(encode_upper(`RV_OP_LUI, 5'd9, 20'h12345));
        add_store(encode_store(`RV_F3_SW, 5'd9, 5'd10, 12'd24), 32'h218, 32'h1234_5000, 4'hF);
        add_step(encode_imm(`RV_OP_LOAD, `RV_F3_LW, 5'd11, 5'd10, 12'h100));
        add_store(encode_store(`RV_F3_SW, 5'd11, 5'd10, 12'd28), 32'h21C, LOAD_WORD, 4'hF);
        add_step(encode_imm(`RV_OP_LOAD, `RV_F3_LBU, 5'd12, 5'd10, 12'h103)); // Top byte 0x81
        add_store(encode_store(`RV_F3_SW, 5'd12, 5'd10, 12'd32), 32'h220, 32'h0000_0081, 4'hF);
        add_store(encode_store(`RV_F3_SB, 5'd7, 5'd10, 12'd36), 32'h224, 32'h9D9D_9D9D, 4'b0001);
        add_store(encode_store(`RV_F3_SB, 5'd7, 5'd10, 12'd37), 32'h225, 32'h9D9D_9D9D, 4'b0010);
        add_store(encode_store(`RV_F3_SB, 5'd7, 5'd10, 12'd38), 32'h226, 32'h9D9D_9D9D, 4'b0100);
        add_store(encode_store(`RV_F3_SB, 5'd7, 5'd10, 12'd39), 32'h227, 32'h9D9D_9D9D, 4'b1000);
        add_step(encode_branch(`RV_F3_BEQ, 5'd1, 5'd1, 13'd8));           // Taken
        add_step(encode_store(`RV_F3_SW, 5'd1, 5'd10, 12'd40));
        add_step(encode_branch(`RV_F3_BNE, 5'd1, 5'd1, 13'd8));           // Falls through
        add_store(encode_store(`RV_F3_SW, 5'd1, 5'd10, 12'd44), 32'h22C, 32'h0000_0064, 4'hF);
        add_step(encode_jal(5'd13, 21'd12));                              // Link is 0x78
        add_step(encode_store(`RV_F3_SW, 5'd1, 5'd10, 12'd48));
        add_step(encode_store(`RV_F3_SW, 5'd1, 5'd10, 12'd52));
        add_store(encode_store(`RV_F3_SW, 5'd13, 5'd10, 12'd56), 32'h238, 32'h0000_0078, 4'hF);
        add_step(encode_imm(`RV_OP_IMM, `RV_F3_ADD, 5'd0, 5'd0, 12'd55));
        add_store(encode_store(`RV_F3_SW, 5'd0, 5'd10, 12'd60), 32'h23C, 32'h0000_0000, 4'hF);
        add_step(encode_upper(7'b0010111, 5'd1, 20'h00001));              // AUIPC traps
        add_step(encode_store(`RV_F3_SW, 5'd1, 5'd10, 12'd64));
    endtask

    task automatic compare_word(input string name, input rv_word_t expected,
                                input rv_word_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_sel(input string name, input rv_sel_t expected,
                               input rv_sel_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic wait_for_store();
        @(posedge clk);
        while (!log_valid)
            @(posedge clk);
    endtask

    always @(posedge clk)
    begin
        if (log_valid)
            stores_seen++;
    end

    initial
    begin
        errors          = 0;
        checks          = 0;
        stores_expected = 0;
        bus_after_trap  = 0;
        build_program();
        watchdog_cycles = tbl_instr.size() * CYCLES_PER_STEP + RESET_CYCLES + IDLE_CYCLES;
        mem0.fill_pattern();
        for (int i = 0; i < tbl_instr.size(); i++)
            mem0.preload_word(`RV_RESET_ADDR + 4 * i, tbl_instr[i]);
        mem0.preload_word(LOAD_ADDR, LOAD_WORD);

        while (reset_n !== 1'b1)
            @(posedge clk);
        for (int i = 0; i < tbl_instr.size(); i++)
        begin
            if (tbl_store[i])
            begin
                wait_for_store();
                compare_word("o_wb_adr", tbl_adr[i], log_adr);
                compare_word("o_wb_dat", tbl_dat[i], log_dat);
                compare_sel("o_wb_sel", tbl_sel[i], log_sel);
            end
        end

        while (!trap)
            @(posedge clk);
        repeat (IDLE_CYCLES)
        begin
            @(posedge clk);
            if (wb_cyc || wb_stb)
                bus_after_trap++;
        end
        if (bus_after_trap != 0)
        begin
            errors++;
            $display("Bus cycles continued after the trap on %0d cycles", bus_after_trap);
        end
        if (stores_seen != stores_expected)
        begin
            errors++;
            $display("The core made %0d stores where %0d were expected",
                     stores_seen, stores_expected);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        @(posedge clk);
        repeat (watchdog_cycles)
            @(posedge clk);
        $display("Timeout after %0d cycles, the core hangs in state %s at pc %h",
                 watchdog_cycles, dut0.state_q.name(), dut0.pc);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regs.sv
rtl/rv_alu.sv
rtl/rv_core.sv
sim/rv_clock_gen.sv
sim/rv_tb_mem.sv
sim/rv_tb.sv

// ==== Makefile ====
# Any of these can be overridden on the command line, e.g. make sim LOG=run.log
VERILATOR ?= verilator
TOP       ?= rv_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# The run passes only when the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
